// ==== source/trace_pkg.sv ====
package trace_pkg;

    // Pipeline stages in program order and slot index
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } stage_t;

    // Instruction classes carried along with each tag
    typedef enum logic [2:0] {
        ALU    = 3'd0,
        LOAD   = 3'd1,
        STORE  = 3'd2,
        BRANCH = 3'd3,
        NOP    = 3'd4
    } op_t;

    // Record field widths
    localparam int TAG_W   = 8;
    localparam int STALL_W = 4;
    localparam int STAMP_W = 16;

    // Stall count stops here
    localparam logic [STALL_W-1:0] STALL_MAX = '1;

    // One slot per stage
    localparam int NUM_STAGES = 5;

    // Retire side sizing
    localparam int QUEUE_DEPTH    = 4;
    localparam int RETIRE_CREDITS = 4;

    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int COUNT_W     = $clog2(QUEUE_DEPTH + 1);
    localparam int CREDIT_W    = $clog2(RETIRE_CREDITS + 1);

endpackage

// ==== source/stage_tracker.sv ====
`timescale 1ns/1ns

module stage_tracker
    import trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  logic [TAG_W-1:0]   issue_tag,
    input  op_t                issue_op,
    input  logic               stall,
    input  logic               hold,
    output logic               issue_ready,
    output logic               wb_valid,
    output logic [TAG_W-1:0]   wb_tag,
    output op_t                wb_op,
    output logic [STALL_W-1:0] wb_stalls,
    output logic [STAMP_W-1:0] wb_stamp
);

    // One slot per stage indexed by stage_t
    logic               slot_valid  [NUM_STAGES];
    logic [TAG_W-1:0]   slot_tag    [NUM_STAGES];
    op_t                slot_op     [NUM_STAGES];
    logic [STALL_W-1:0] slot_stalls [NUM_STAGES];

    logic [STAMP_W-1:0] cycle_cnt;
    logic               running;

    // Fetch and decode move only without stall and hold
    logic               front_adv;
    // Execute, memory and writeback move unless held
    logic               back_adv;
    logic               count_stall;
    logic               issue_fire;

    function automatic logic [STALL_W-1:0] sat_inc(input logic [STALL_W-1:0] count);
        logic [STALL_W-1:0] result;
        if (count == STALL_MAX) begin
            result = count;
        end else begin
            result = count + 1'b1;
        end
        return result;
    endfunction

    assign front_adv   = !stall && !hold;
    assign back_adv    = !hold;
    // A held cycle is not a stall cycle
    assign count_stall = stall && !hold;

    // Fetch always empties into decode when the front end advances,
    // so an occupied fetch slot blocks issue only under stall or hold
    assign issue_ready = running && front_adv;
    assign issue_fire  = issue_valid && issue_ready;

    // Ready stays low for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // Free-running cycle counter that wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Slot occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_STAGES; i++) begin
                slot_valid[i] <= 1'b0;
            end
        end else if (hold) begin
            // Writeback still drains into the queue's reserved entry
            slot_valid[WRITEBACK] <= 1'b0;
        end else begin
            slot_valid[WRITEBACK] <= slot_valid[MEMORY];
            slot_valid[MEMORY]    <= slot_valid[EXECUTE];
            // Stall turns execute into a bubble
            slot_valid[EXECUTE]   <= slot_valid[DECODE] && !stall;
            if (!stall) begin
                slot_valid[DECODE] <= slot_valid[FETCH];
                slot_valid[FETCH]  <= issue_fire;
            end
        end
    end

    // Slot payload follows the occupancy moves
    always_ff @(posedge clk) begin
        if (back_adv) begin
            for (int i = EXECUTE; i <= WRITEBACK; i++) begin
                slot_tag[i]    <= slot_tag[i-1];
                slot_op[i]     <= slot_op[i-1];
                slot_stalls[i] <= slot_stalls[i-1];
            end
        end
        if (front_adv) begin
            slot_tag[DECODE]    <= slot_tag[FETCH];
            slot_op[DECODE]     <= slot_op[FETCH];
            slot_stalls[DECODE] <= slot_stalls[FETCH];
            slot_tag[FETCH]     <= issue_tag;
            slot_op[FETCH]      <= issue_op;
            slot_stalls[FETCH]  <= '0;
        end else if (count_stall) begin
            // Both front stages sit still and each gets charged a cycle
            slot_stalls[FETCH]  <= sat_inc(slot_stalls[FETCH]);
            slot_stalls[DECODE] <= sat_inc(slot_stalls[DECODE]);
        end
    end

    // Retirement event is the writeback slot itself
    assign wb_valid  = slot_valid[WRITEBACK];
    assign wb_tag    = slot_tag[WRITEBACK];
    assign wb_op     = slot_op[WRITEBACK];
    assign wb_stalls = slot_stalls[WRITEBACK];
    assign wb_stamp  = cycle_cnt;

    // A held cycle drains writeback and refills nothing behind it
    a_hold_blocks_wb: assert property (
        @(posedge clk) disable iff (rst)
        hold |=> !wb_valid
    );

    // Fetch slot does not take a new instruction across a stall cycle
    a_no_issue_in_stall: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> $stable(slot_valid[FETCH]) && $stable(slot_tag[FETCH])
    );

endmodule

// ==== source/retire_queue.sv ====
`timescale 1ns/1ns

module retire_queue
    import trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_valid,
    input  logic [TAG_W-1:0]   wb_tag,
    input  op_t                wb_op,
    input  logic [STALL_W-1:0] wb_stalls,
    input  logic [STAMP_W-1:0] wb_stamp,
    input  logic               retire_credit,
    output logic               hold,
    output logic               retire_valid,
    output logic [TAG_W-1:0]   retire_tag,
    output op_t                retire_op,
    output logic [STALL_W-1:0] retire_stalls,
    output logic [STAMP_W-1:0] retire_stamp
);

    // Record storage
    logic [TAG_W-1:0]     mem_tag    [QUEUE_DEPTH];
    op_t                  mem_op     [QUEUE_DEPTH];
    logic [STALL_W-1:0]   mem_stalls [QUEUE_DEPTH];
    logic [STAMP_W-1:0]   mem_stamp  [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [COUNT_W-1:0]     count;
    logic [CREDIT_W-1:0]    credits;

    logic push;
    logic pop;

    function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] ptr);
        logic [QUEUE_PTR_W-1:0] result;
        if (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    assign push = wb_valid;
    // Head goes out whenever a credit is left to pay for it
    assign pop  = (count != '0) && (credits != '0);

    // One free entry stays reserved for the record leaving writeback
    assign hold = count >= COUNT_W'(QUEUE_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (push) begin
            mem_tag[wr_ptr]    <= wb_tag;
            mem_op[wr_ptr]     <= wb_op;
            mem_stalls[wr_ptr] <= wb_stalls;
            mem_stamp[wr_ptr]  <= wb_stamp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Credit counter saturating at the reset grant
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(RETIRE_CREDITS);
        end else begin
            case ({pop, retire_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    if (credits != CREDIT_W'(RETIRE_CREDITS)) begin
                        credits <= credits + 1'b1;
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

    assign retire_valid  = pop;
    assign retire_tag    = mem_tag[rd_ptr];
    assign retire_op     = mem_op[rd_ptr];
    assign retire_stalls = mem_stalls[rd_ptr];
    assign retire_stamp  = mem_stamp[rd_ptr];

    // Tracker must never push into a full queue
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        push |-> count < COUNT_W'(QUEUE_DEPTH)
    );

    a_credit_limit: assert property (
        @(posedge clk) disable iff (rst)
        credits <= CREDIT_W'(RETIRE_CREDITS)
    );

    // Spending the last credit without a return stops the output next cycle
    a_last_credit: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid && (credits == CREDIT_W'(1)) && !retire_credit |=> !retire_valid
    );

endmodule

// ==== source/pipe_trace_top.sv ====
`timescale 1ns/1ns

module pipe_trace_top
    import trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  logic [TAG_W-1:0]   issue_tag,
    input  op_t                issue_op,
    output logic               issue_ready,
    input  logic               stall,
    input  logic               retire_credit,
    output logic               retire_valid,
    output logic [TAG_W-1:0]   retire_tag,
    output op_t                retire_op,
    output logic [STALL_W-1:0] retire_stalls,
    output logic [STAMP_W-1:0] retire_stamp
);

    // Writeback record from tracker to queue
    logic               wb_valid;
    logic [TAG_W-1:0]   wb_tag;
    op_t                wb_op;
    logic [STALL_W-1:0] wb_stalls;
    logic [STAMP_W-1:0] wb_stamp;
    // Back-pressure from queue to tracker
    logic               hold;

    stage_tracker stage_tracker_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .issue_op    (issue_op),
        .stall       (stall),
        .hold        (hold),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .wb_op       (wb_op),
        .wb_stalls   (wb_stalls),
        .wb_stamp    (wb_stamp)
    );

    retire_queue retire_queue_i (
        .clk           (clk),
        .rst           (rst),
        .wb_valid      (wb_valid),
        .wb_tag        (wb_tag),
        .wb_op         (wb_op),
        .wb_stalls     (wb_stalls),
        .wb_stamp      (wb_stamp),
        .retire_credit (retire_credit),
        .hold          (hold),
        .retire_valid  (retire_valid),
        .retire_tag    (retire_tag),
        .retire_op     (retire_op),
        .retire_stalls (retire_stalls),
        .retire_stamp  (retire_stamp)
    );

endmodule

// ==== bench/pipe_trace_tests.svh ====
task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
endtask

task automatic apply_reset();
    rst = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    if (issue_ready !== 1'b0 || retire_valid !== 1'b0) begin
        report_problem("issue_ready or retire_valid high during reset");
    end
    rst = 1'b0;
endtask

task automatic drive_random_issue();
    issue_tag = TAG_W'(random_bits(TAG_W));
    issue_op  = random_op();
endtask

// Holds issue_valid until the instruction is taken
task automatic issue_one();
    int start;
    start = issued_cnt;
    drive_random_issue();
    issue_valid = 1'b1;
    while (issued_cnt == start) begin
        next_cycle();
    end
    issue_valid = 1'b0;
endtask

task automatic issue_burst(input int count);
    int target;
    target = issued_cnt + count;
    drive_random_issue();
    issue_valid = 1'b1;
    while (issued_cnt != target) begin
        next_cycle();
        drive_random_issue();
    end
    issue_valid = 1'b0;
endtask

task automatic apply_stall(input int cycles);
    stall = 1'b1;
    repeat (cycles) next_cycle();
    stall = 1'b0;
endtask

task automatic wait_all_retired();
    while (retired_cnt != issued_cnt) begin
        next_cycle();
    end
endtask

task automatic test_single();
    test_name     = "single";
    check_stalls  = 1'b1;
    check_timing  = 1'b1;
    // A credit back every cycle keeps the queue draining
    retire_credit = 1'b1;
    issue_one();
    wait_all_retired();
endtask

task automatic test_back_to_back();
    test_name = "back_to_back";
    issue_burst(NUM_STAGES);
    wait_all_retired();
endtask

task automatic test_stall();
    int start;
    test_name = "stall";
    issue_one();
    apply_stall(3);
    issue_one();
    apply_stall(2);
    // Offer an issue across a stall long enough to saturate the counts
    start = issued_cnt;
    drive_random_issue();
    issue_valid = 1'b1;
    stall       = 1'b1;
    repeat (int'(STALL_MAX) + 5) next_cycle();
    if (issued_cnt != start) begin
        report_problem("an instruction was accepted while stall was high");
    end
    stall = 1'b0;
    while (issued_cnt == start) begin
        next_cycle();
    end
    issue_valid = 1'b0;
    apply_stall(1);
    issue_burst(2);
    apply_stall(4);
    wait_all_retired();
endtask

task automatic test_credit_backpressure();
    int base;
    test_name     = "credit_backpressure";
    check_timing  = 1'b0;
    retire_credit = 1'b0;
    base          = retired_cnt;
    drive_random_issue();
    issue_valid = 1'b1;
    while (!(retired_cnt - base == RETIRE_CREDITS && !issue_ready)) begin
        next_cycle();
        drive_random_issue();
    end
    issue_valid = 1'b0;
    repeat (2 * QUEUE_DEPTH) next_cycle();
    if (retired_cnt - base != RETIRE_CREDITS) begin
        report_problem("more records retired than the credits allowed");
    end
    if (issue_ready) begin
        report_problem("issue_ready rose again before any credit came back");
    end
    if (issued_cnt == retired_cnt) begin
        report_problem("no records were left waiting for credits");
    end
    retire_credit = 1'b1;
    wait_all_retired();
    // Refill the credit count before the next test
    repeat (RETIRE_CREDITS) next_cycle();
endtask

task automatic test_random_traffic();
    test_name    = "random_traffic";
    check_stalls = 1'b0;
    check_timing = 1'b0;
    repeat (RANDOM_CYCLES) begin
        issue_valid   = (random_bits(1) == 32'd1);
        drive_random_issue();
        // Stall about one cycle in four
        stall         = (random_bits(2) == 32'd3);
        retire_credit = (random_bits(1) == 32'd1);
        next_cycle();
    end
    issue_valid   = 1'b0;
    stall         = 1'b0;
    retire_credit = 1'b1;
    wait_all_retired();
    repeat (RETIRE_CREDITS) next_cycle();
    if (issued_cnt == 0) begin
        report_problem("no instruction was ever accepted");
    end
endtask

// ==== bench/pipe_trace_tb.sv ====
`timescale 1ns/1ns

module pipe_trace_tb
    import trace_pkg::*;
();

    localparam int CLK_HALF        = 2;
    localparam int DRIVE_DELAY     = 1;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_BUDGET = 100;
    localparam int RANDOM_CYCLES   = 400;
    // Four directed tests plus the random run and its drain
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 4 * DIRECTED_BUDGET + 2 * RANDOM_CYCLES;
    localparam logic [31:0] LFSR_SEED = 32'hc2bd;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic               clk;
    logic               rst;
    logic               issue_valid;
    logic [TAG_W-1:0]   issue_tag;
    op_t                issue_op;
    logic               issue_ready;
    logic               stall;
    logic               retire_credit;
    logic               retire_valid;
    logic [TAG_W-1:0]   retire_tag;
    op_t                retire_op;
    logic [STALL_W-1:0] retire_stalls;
    logic [STAMP_W-1:0] retire_stamp;

    // Expected records by issue order
    logic [TAG_W-1:0]   sb_tag    [$];
    op_t                sb_op     [$];
    logic [STALL_W-1:0] sb_stalls [$];
    int                 sb_delay  [$];
    int                 sb_accept [$];
    // Instructions still in fetch or decode
    int                 front_idx   [$];
    int                 front_moves [$];

    int                 issued_cnt;
    int                 retired_cnt;
    int                 next_cyc;
    int                 credit_model;
    int                 timeout_cnt;
    logic [STAMP_W-1:0] last_stamp;
    logic               have_last_stamp;
    logic               check_stalls;
    logic               check_timing;
    logic [31:0]        lfsr_state;
    string              test_name;

    pipe_trace_top pipe_trace_top_i (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_tag     (issue_tag),
        .issue_op      (issue_op),
        .issue_ready   (issue_ready),
        .stall         (stall),
        .retire_credit (retire_credit),
        .retire_valid  (retire_valid),
        .retire_tag    (retire_tag),
        .retire_op     (retire_op),
        .retire_stalls (retire_stalls),
        .retire_stamp  (retire_stamp)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] stepped;
        stepped = state >> 1;
        if (state[0]) begin
            stepped = stepped ^ LFSR_TAPS;
        end
        return stepped;
    endfunction

    // One LFSR step for every bit handed out
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic op_t random_op();
        logic [31:0] pick;
        op_t         op;
        pick = random_bits(3) % 5;
        case (pick)
            0:       op = ALU;
            1:       op = LOAD;
            2:       op = STORE;
            3:       op = BRANCH;
            default: op = NOP;
        endcase
        return op;
    endfunction

    task automatic end_in_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("%s: %s", test_name, what);
        end_in_failure();
    endtask

    task automatic compare_tag(input logic [TAG_W-1:0] expected, input logic [TAG_W-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: tag expected %h actual %h", test_name, expected, actual);
            end_in_failure();
        end
    endtask

    task automatic compare_op(input op_t expected, input op_t actual);
        if (actual !== expected) begin
            $display("error %s: opcode expected %0d actual %0d", test_name, expected, actual);
            end_in_failure();
        end
    endtask

    task automatic compare_stalls(input logic [STALL_W-1:0] expected,
                                  input logic [STALL_W-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: stalls expected %0d actual %0d", test_name, expected, actual);
            end_in_failure();
        end
    endtask

    task automatic compare_stamp(input logic [STAMP_W-1:0] expected,
                                 input logic [STAMP_W-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: stamp expected %0d actual %0d", test_name, expected, actual);
            end_in_failure();
        end
    endtask

    // Stamps must move forward modulo wrap
    task automatic check_stamp_order(input logic [STAMP_W-1:0] actual);
        logic [STAMP_W-1:0] step;
        step = actual - last_stamp;
        if (have_last_stamp && (step == '0 || step[STAMP_W-1])) begin
            report_problem($sformatf("stamp %0d does not come after stamp %0d",
                                     actual, last_stamp));
        end
        last_stamp      = actual;
        have_last_stamp = 1'b1;
    endtask

    // Stall holds fetch and decode while any other cycle moves them one stage
    task automatic track_front();
        int dropped;
        for (int i = 0; i < front_idx.size(); i++) begin
            if (stall) begin
                sb_delay[front_idx[i]] = sb_delay[front_idx[i]] + 1;
                if (sb_stalls[front_idx[i]] != STALL_MAX) begin
                    sb_stalls[front_idx[i]] = sb_stalls[front_idx[i]] + 1'b1;
                end
            end else begin
                front_moves[i] = front_moves[i] + 1;
            end
        end
        while (front_moves.size() > 0 && front_moves[0] >= int'(EXECUTE)) begin
            dropped = front_idx.pop_front();
            dropped = front_moves.pop_front();
        end
    endtask

    task automatic record_issue(input int cyc);
        sb_tag.push_back(issue_tag);
        sb_op.push_back(issue_op);
        sb_stalls.push_back('0);
        sb_delay.push_back(0);
        sb_accept.push_back(cyc);
        front_idx.push_back(issued_cnt);
        front_moves.push_back(0);
        issued_cnt = issued_cnt + 1;
    endtask

    task automatic check_retirement(input int cyc);
        int idx;
        idx = retired_cnt;
        if (credit_model == 0) begin
            report_problem("retire_valid high with no credit left");
        end
        if (idx >= issued_cnt) begin
            report_problem("a record retired with no instruction outstanding");
        end
        compare_tag(sb_tag[idx], retire_tag);
        compare_op(sb_op[idx], retire_op);
        if (check_stalls) begin
            compare_stalls(sb_stalls[idx], retire_stalls);
        end
        if (check_timing) begin
            // Writeback is five cycles past the issue cycle plus stall cycles
            compare_stamp(STAMP_W'(sb_accept[idx] + 5 + sb_delay[idx]), retire_stamp);
            compare_stamp(STAMP_W'(cyc - 1), retire_stamp);
        end
        check_stamp_order(retire_stamp);
        retired_cnt = retired_cnt + 1;
    endtask

    // Samples what the DUT sees at each rising edge
    always @(posedge clk) begin : monitor
        int cyc;
        if (rst) begin
            next_cyc = 0;
        end else begin
            cyc      = next_cyc;
            next_cyc = next_cyc + 1;
            track_front();
            if (stall && issue_ready) begin
                report_problem("issue_ready high during a stall cycle");
            end
            if (issue_valid && issue_ready) begin
                record_issue(cyc);
            end
            if (retire_valid) begin
                check_retirement(cyc);
                credit_model = credit_model - 1;
            end
            if (retire_credit && credit_model < RETIRE_CREDITS) begin
                credit_model = credit_model + 1;
            end
        end
    end

    always @(posedge clk) begin
        timeout_cnt = timeout_cnt + 1;
        if (timeout_cnt >= TIMEOUT_CYCLES) begin
            report_problem($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    `include "pipe_trace_tests.svh"

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        issue_valid     = 1'b0;
        issue_tag       = '0;
        issue_op        = ALU;
        stall           = 1'b0;
        retire_credit   = 1'b0;
        lfsr_state      = LFSR_SEED;
        issued_cnt      = 0;
        retired_cnt     = 0;
        next_cyc        = 0;
        credit_model    = RETIRE_CREDITS;
        timeout_cnt     = 0;
        last_stamp      = '0;
        have_last_stamp = 1'b0;
        check_stalls    = 1'b1;
        check_timing    = 1'b1;
        test_name       = "reset";
        apply_reset();
        test_single();
        test_back_to_back();
        test_stall();
        test_credit_backpressure();
        test_random_traffic();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+bench
source/trace_pkg.sv
source/stage_tracker.sv
source/retire_queue.sv
source/pipe_trace_top.sv
bench/pipe_trace_tb.sv
